// File: Makefile
TOP := tb_pattern_writer

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: compile.f
+incdir+verif
hdl/video_pkg.sv
hdl/mem_pkg.sv
hdl/evt_counter.sv
hdl/test_pattern_generator.sv
hdl/pattern_stacker.sv
hdl/stream_fifo.sv
hdl/pattern_writer_top.sv
verif/tb_pattern_writer.sv

// File: hdl/evt_counter.sv
`timescale 1ns/1ps

module evt_counter #(
  parameter int MAX_COUNT = 160
) (
  input  logic                         clk_in,
  input  logic                         reset,
  input  logic                         evt,
  output logic [$clog2(MAX_COUNT)-1:0] count
);

  // Wraps back to zero after MAX_COUNT - 1
  always_ff @(posedge clk_in) begin
    if (reset) begin
      count <= '0;
    end else if (evt) begin
      if (count == MAX_COUNT - 1) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

// File: hdl/mem_pkg.sv
package mem_pkg;

  // Memory is addressed in whole 128-bit blocks
  localparam int ADDR_WIDTH = 27;
  localparam int BLOCK_WIDTH = 128;

  // Entries per queue
  localparam int QUEUE_DEPTH = 16;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [BLOCK_WIDTH-1:0] block_t;

  // Block address with end-of-frame marker
  typedef struct packed {
    addr_t addr;
    logic  last;
  } addr_entry_t;

endpackage

// File: hdl/pattern_stacker.sv
`timescale 1ns/1ps

module pattern_stacker (
  input  logic                 clk_in,
  input  logic                 reset,
  input  video_pkg::pattern_t  pattern,
  input  logic                 push_ready,
  output logic                 push,
  output mem_pkg::addr_entry_t entry,
  output mem_pkg::block_t      block
);

  video_pkg::block_idx_t hcount;
  video_pkg::vcount_t    vcount;
  logic                  line_end;
  logic                  frame_end;
  mem_pkg::addr_t        block_addr;

  // A block is offered exactly when both queues can take it
  assign push = push_ready;

  assign line_end  = (hcount == video_pkg::BLOCKS_PER_LINE - 1);
  assign frame_end = line_end && (vcount == video_pkg::VRES - 1);

  // Block column within the line
  evt_counter #(
    .MAX_COUNT(video_pkg::BLOCKS_PER_LINE)
  ) hcounter (
    .clk_in(clk_in),
    .reset (reset),
    .evt   (push),
    .count (hcount)
  );

  // Row, steps after the last block of a line
  evt_counter #(
    .MAX_COUNT(video_pkg::VRES)
  ) vcounter (
    .clk_in(clk_in),
    .reset (reset),
    .evt   (push && line_end),
    .count (vcount)
  );

  // Linear block address, row * 160 + column
  assign block_addr = mem_pkg::addr_t'(vcount) *
                      mem_pkg::addr_t'(video_pkg::BLOCKS_PER_LINE) +
                      mem_pkg::addr_t'(hcount);

  assign entry.addr = block_addr;
  assign entry.last = frame_end;

  // Pixel i lands in bits 16i+15 down to 16i
  for (genvar i = 0; i < video_pkg::PIXELS_PER_BLOCK; i++) begin : g_pixel
    video_pkg::hcount_t column;
    video_pkg::rgb565_t pixel;

    assign column = video_pkg::hcount_t'(hcount * video_pkg::PIXELS_PER_BLOCK + i);

    test_pattern_generator pattern_gen (
      .sel   (pattern),
      .hcount(column),
      .vcount(vcount),
      .pixel (pixel)
    );

    assign block[i*$bits(video_pkg::rgb565_t) +: $bits(video_pkg::rgb565_t)] = pixel;
  end

endmodule

// File: hdl/pattern_writer_top.sv
`timescale 1ns/1ps

module pattern_writer_top (
  input  logic                clk_in,
  input  logic                reset,
  input  video_pkg::pattern_t pattern,
  input  logic                wr_ready,
  output logic                wr_valid,
  output mem_pkg::addr_t      wr_addr,
  output mem_pkg::block_t     wr_data,
  output logic                wr_last
);

  logic                 push;
  logic                 push_ready;
  logic                 addr_full;
  logic                 data_full;
  logic                 addr_empty;
  logic                 pop;
  mem_pkg::addr_entry_t entry;
  mem_pkg::addr_entry_t head_entry;
  mem_pkg::block_t      block;

  // Both queues must have room before a block is built
  assign push_ready = !(addr_full || data_full);

  // Queues move in lockstep, so one transfer pops both
  assign wr_valid = !addr_empty;
  assign pop      = wr_valid && wr_ready;

  assign wr_addr = head_entry.addr;
  assign wr_last = head_entry.last;

  pattern_stacker stacker (
    .clk_in    (clk_in),
    .reset     (reset),
    .pattern   (pattern),
    .push_ready(push_ready),
    .push      (push),
    .entry     (entry),
    .block     (block)
  );

  stream_fifo #(
    .payload_t(mem_pkg::addr_entry_t)
  ) addr_fifo (
    .clk_in   (clk_in),
    .reset    (reset),
    .push     (push),
    .push_data(entry),
    .full     (addr_full),
    .pop      (pop),
    .pop_data (head_entry),
    .empty    (addr_empty)
  );

  // Same occupancy as the address queue, its empty flag is not needed
  stream_fifo #(
    .payload_t(mem_pkg::block_t)
  ) data_fifo (
    .clk_in   (clk_in),
    .reset    (reset),
    .push     (push),
    .push_data(block),
    .full     (data_full),
    .pop      (pop),
    .pop_data (wr_data),
    .empty    ()
  );

endmodule

// File: hdl/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
  parameter type payload_t = mem_pkg::block_t,
  parameter int  DEPTH     = mem_pkg::QUEUE_DEPTH
) (
  input  logic     clk_in,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  output logic     full,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty
);

  payload_t                   mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       out_valid;
  logic                       push_fire;
  logic                       pop_fire;
  logic                       slot_open;
  logic                       bypass;
  logic                       mem_read;
  logic                       mem_write;

  assign full  = (count == DEPTH);
  assign empty = !out_valid;

  assign push_fire = push && !full;
  assign pop_fire  = pop && out_valid;

  // Output slot can take a new head this cycle
  assign slot_open = !out_valid || pop_fire;

  // Empty buffer, so a push goes straight to the output slot
  assign bypass    = push_fire && slot_open && (count == '0);
  assign mem_read  = slot_open && (count != '0);
  assign mem_write = push_fire && !bypass;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      out_valid <= 1'b0;
    end else begin
      if (mem_write) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (mem_read) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({mem_write, mem_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (slot_open) begin
        out_valid <= mem_read || bypass;
      end
    end
  end

  // Payload path, head only moves when the slot opens
  always_ff @(posedge clk_in) begin
    if (mem_write) begin
      mem[wr_ptr] <= push_data;
    end
    if (mem_read) begin
      pop_data <= mem[rd_ptr];
    end else if (bypass) begin
      pop_data <= push_data;
    end
  end

endmodule

// File: hdl/test_pattern_generator.sv
`timescale 1ns/1ps

module test_pattern_generator (
  input  video_pkg::pattern_t sel,
  input  video_pkg::hcount_t  hcount,
  input  video_pkg::vcount_t  vcount,
  output video_pkg::rgb565_t  pixel
);

  logic [7:0] red;
  logic [7:0] green;
  logic [7:0] blue;

  // Full 8-bit colour first
  always_comb begin
    red   = 8'h00;
    green = 8'h00;
    blue  = 8'h00;
    case (sel)
      video_pkg::PAT_SOLID: begin
        red  = 8'hFF;
        blue = 8'hFF;
      end
      video_pkg::PAT_CROSS: begin
        if (vcount == video_pkg::CROSS_ROW || hcount == video_pkg::CROSS_COL) begin
          red   = 8'hFF;
          green = 8'hFF;
          blue  = 8'hFF;
        end
      end
      video_pkg::PAT_RAMP: begin
        red   = hcount[7:0];
        green = hcount[7:0];
        blue  = hcount[7:0];
      end
      video_pkg::PAT_MIX: begin
        red   = hcount[7:0];
        green = vcount[7:0];
        blue  = hcount[7:0] + vcount[7:0]; // wraps mod 256
      end
      default: begin
        red = 8'h00;
      end
    endcase
  end

  // Keep the top bits of each channel
  assign pixel.red   = red[7 -: video_pkg::RED_WIDTH];
  assign pixel.green = green[7 -: video_pkg::GREEN_WIDTH];
  assign pixel.blue  = blue[7 -: video_pkg::BLUE_WIDTH];

endmodule

// File: hdl/video_pkg.sv
package video_pkg;

  // Visible frame
  localparam int HRES = 1280;
  localparam int VRES = 720;

  // Eight RGB565 pixels fill one memory word
  localparam int PIXELS_PER_BLOCK = 8;
  localparam int BLOCKS_PER_LINE = HRES / PIXELS_PER_BLOCK;

  localparam int HCOUNT_WIDTH = 11;
  localparam int VCOUNT_WIDTH = 10;

  // Crosshair position, frame centre
  localparam int CROSS_COL = HRES / 2;
  localparam int CROSS_ROW = VRES / 2;

  localparam int RED_WIDTH = 5;
  localparam int GREEN_WIDTH = 6;
  localparam int BLUE_WIDTH = 5;

  typedef logic [HCOUNT_WIDTH-1:0] hcount_t;
  typedef logic [VCOUNT_WIDTH-1:0] vcount_t;
  typedef logic [$clog2(BLOCKS_PER_LINE)-1:0] block_idx_t;

  typedef enum logic [1:0] {
    PAT_SOLID = 2'b00,
    PAT_CROSS = 2'b01,
    PAT_RAMP  = 2'b10,
    PAT_MIX   = 2'b11
  } pattern_t;

  typedef struct packed {
    logic [RED_WIDTH-1:0]   red;
    logic [GREEN_WIDTH-1:0] green;
    logic [BLUE_WIDTH-1:0]  blue;
  } rgb565_t;

endpackage

// File: verif/tb_pattern_model.svh
`ifndef TB_PATTERN_MODEL_SVH
`define TB_PATTERN_MODEL_SVH

// Blocks in one full frame
localparam int FRAME_BLOCKS = video_pkg::BLOCKS_PER_LINE * video_pkg::VRES;

// Reference colour for one pixel, 8-bit channels cut down to RGB565
function automatic video_pkg::rgb565_t expected_pixel(input video_pkg::pattern_t sel,
                                                      input int col, input int row);
  logic [7:0]         r;
  logic [7:0]         g;
  logic [7:0]         b;
  video_pkg::rgb565_t pix;
  r = 8'h00;
  g = 8'h00;
  b = 8'h00;
  case (sel)
    video_pkg::PAT_SOLID: begin
      r = 8'd255;
      b = 8'd255;
    end
    video_pkg::PAT_CROSS: begin
      // Crosshair through the frame centre
      if (row == video_pkg::VRES / 2 || col == video_pkg::HRES / 2) begin
        r = 8'd255;
        g = 8'd255;
        b = 8'd255;
      end
    end
    video_pkg::PAT_RAMP: begin
      r = 8'(col % 256);
      g = 8'(col % 256);
      b = 8'(col % 256);
    end
    default: begin
      r = 8'(col % 256);
      g = 8'(row % 256);
      b = 8'((col + row) % 256);
    end
  endcase
  pix.red   = r[7:3];
  pix.green = g[7:2];
  pix.blue  = b[7:3];
  return pix;
endfunction

// Eight pixels of the block at a linear address, pixel 0 in the low bits
function automatic mem_pkg::block_t expected_block(input video_pkg::pattern_t sel,
                                                   input int addr);
  mem_pkg::block_t word;
  int              row;
  int              blk;
  row = addr / video_pkg::BLOCKS_PER_LINE;
  blk = addr % video_pkg::BLOCKS_PER_LINE;
  for (int i = 0; i < video_pkg::PIXELS_PER_BLOCK; i++) begin
    word[i*16 +: 16] = expected_pixel(sel, blk * video_pkg::PIXELS_PER_BLOCK + i, row);
  end
  return word;
endfunction

function automatic logic expected_last(input int addr);
  return addr == FRAME_BLOCKS - 1;
endfunction

// Address sequence wraps at the end of the frame
function automatic int next_addr(input int addr);
  return (addr + 1) % FRAME_BLOCKS;
endfunction

`endif

// File: verif/tb_pattern_writer.sv
`timescale 1ns/1ps

module tb_pattern_writer;

  `include "tb_pattern_model.svh"

  localparam int DUTY_ALWAYS = 1;
  localparam int DUTY_HALF = 2;
  localparam int DUTY_QUARTER = 4;
  localparam int NUM_RUNS = 7;
  localparam mem_pkg::block_t SOLID_BLOCK = {8{16'hF81F}};

  // One row per run
  typedef struct packed {
    video_pkg::pattern_t pattern;
    int                  duty;
    int                  beats;
  } run_t;

  run_t runs [NUM_RUNS] = '{
    '{video_pkg::PAT_SOLID, DUTY_ALWAYS,  400},
    '{video_pkg::PAT_SOLID, DUTY_HALF,    300},
    '{video_pkg::PAT_RAMP,  DUTY_HALF,    600},
    '{video_pkg::PAT_CROSS, DUTY_ALWAYS,  57700},
    '{video_pkg::PAT_CROSS, DUTY_QUARTER, 500},
    '{video_pkg::PAT_MIX,   DUTY_QUARTER, 800},
    '{video_pkg::PAT_MIX,   DUTY_ALWAYS,  115201}
  };

  logic                clk_in;
  logic                reset;
  video_pkg::pattern_t pattern;
  logic                wr_ready;
  logic                wr_valid;
  mem_pkg::addr_t      wr_addr;
  mem_pkg::block_t     wr_data;
  logic                wr_last;
  integer              seed = 75589;

  pattern_writer_top pattern_writer_top_inst (
    .clk_in  (clk_in),
    .reset   (reset),
    .pattern (pattern),
    .wr_ready(wr_ready),
    .wr_valid(wr_valid),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .wr_last (wr_last)
  );

  always #50 clk_in = ~clk_in;

  task automatic stop_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_addr(input mem_pkg::addr_t expected, input mem_pkg::addr_t actual);
    if (actual !== expected) begin
      $display("[FAIL] wr_addr expected 0x%h actual 0x%h", expected, actual);
      stop_run();
    end
  endtask

  task automatic check_data(input mem_pkg::block_t expected, input mem_pkg::block_t actual);
    if (actual !== expected) begin
      $display("[FAIL] wr_data expected 0x%h actual 0x%h", expected, actual);
      stop_run();
    end
  endtask

  task automatic check_last(input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[FAIL] wr_last expected 0x%h actual 0x%h", expected, actual);
      stop_run();
    end
  endtask

  task automatic check_valid(input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[FAIL] wr_valid expected 0x%h actual 0x%h", expected, actual);
      stop_run();
    end
  endtask

  // Ready high on roughly one cycle in duty
  function automatic logic draw_ready(input int duty);
    return ($unsigned($random(seed)) % duty) == 0;
  endfunction

  task automatic apply_reset(input video_pkg::pattern_t pat);
    @(posedge clk_in);
    #1;
    reset    = 1'b1;
    wr_ready = 1'b0;
    pattern  = pat;
    repeat (5) begin
      @(posedge clk_in);
      #1;
      check_valid(1'b0, wr_valid);
    end
    reset = 1'b0;
  endtask

  // DUT outputs change only on the clock edge
  task automatic run_row(input run_t run);
    int              exp_addr;
    int              beats_done;
    logic            stalled;
    mem_pkg::addr_t  held_addr;
    mem_pkg::block_t held_data;
    logic            held_last;
    mem_pkg::block_t exp_data;
    exp_addr   = 0;
    beats_done = 0;
    stalled    = 1'b0;
    apply_reset(run.pattern);
    while (beats_done < run.beats) begin
      @(posedge clk_in);
      #1;
      wr_ready = draw_ready(run.duty);
      // A stalled transfer must hold everything
      if (stalled) begin
        check_valid(1'b1, wr_valid);
        check_addr(held_addr, wr_addr);
        check_data(held_data, wr_data);
        check_last(held_last, wr_last);
      end
      stalled = 1'b0;
      if (wr_valid && wr_ready) begin
        if (run.pattern == video_pkg::PAT_SOLID) begin
          exp_data = SOLID_BLOCK;
        end else begin
          exp_data = expected_block(run.pattern, exp_addr);
        end
        check_addr(mem_pkg::addr_t'(exp_addr), wr_addr);
        check_data(exp_data, wr_data);
        check_last(expected_last(exp_addr), wr_last);
        exp_addr = next_addr(exp_addr);
        beats_done++;
      end else if (wr_valid) begin
        stalled   = 1'b1;
        held_addr = wr_addr;
        held_data = wr_data;
        held_last = wr_last;
      end
    end
  endtask

  // Budget of four cycles per beat plus margin for each reset
  initial begin
    int limit;
    limit = 0;
    foreach (runs[i]) begin
      limit += runs[i].beats * 4 + 20;
    end
    repeat (limit) @(posedge clk_in);
    $display("Watchdog expired, the write port stalled and the transfers did not finish");
    stop_run();
  end

  initial begin
    clk_in   = 1'b0;
    reset    = 1'b1;
    pattern  = video_pkg::PAT_SOLID;
    wr_ready = 1'b0;
    for (int r = 0; r < NUM_RUNS; r++) begin
      run_row(runs[r]);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule
